// ==== tb.f ====
verilog/mem_pkg.sv
verilog/latency_counter.sv
verilog/main_memory.sv
verilog/icache.sv
verilog/mem_subsystem.sv
test/mem_tb.sv

// ==== test/mem_golden.txt ====
# op addr value
# W write, R read expects value, F fetch expects value, P write issued with the next F
W 0010 1111
W 0011 2222
W 0012 3333
W 0013 4444
R 0012 3333
R 0010 1111
F 0011 2222
F 0011 2222
F 0013 4444
F 0010 1111
W 0012 5555
F 0012 5555
F 0013 4444
R 0012 5555
W 0050 6060
W 0052 6262
F 0050 6060
F 0011 2222
F 0052 6262
F 0013 4444
W 0138 7777
R 0038 7777
F 0038 7777
F 0138 7777
W 0024 a0a0
W 0026 a2a2
P 0025 b5b5
F 0025 b5b5
F 0026 a2a2
F 0025 b5b5
R 0025 b5b5
W 00cd c1c1
P 00ce ceee
F 00cd c1c1
F 00ce ceee
R 00ce ceee

// ==== test/mem_tb.sv ====
`timescale 1ns/1ps

module mem_tb;
	import mem_pkg::*;

	localparam int LATENCY = 4;
	localparam int WAIT_LIMIT = LATENCY + 10;

	logic clk;
	logic reset_n;
	logic fetch_req;
	addr_t fetch_addr;
	word_t fetch_word;
	logic fetch_ready;
	logic data_read;
	logic data_write;
	addr_t data_addr;
	word_t data_wdata;
	word_t data_rdata;
	logic data_ready;

	byte ops[$];
	addr_t addrs[$];
	word_t vals[$];
	logic golden_loaded = 1'b0;

	// Expected cache contents.
	logic cached [4];
	logic [3:0] cached_tag [4];

	mem_subsystem dut_i (
		.clk (clk),
		.reset_n (reset_n),
		.fetch_req (fetch_req),
		.fetch_addr (fetch_addr),
		.fetch_word (fetch_word),
		.fetch_ready (fetch_ready),
		.data_read (data_read),
		.data_write (data_write),
		.data_addr (data_addr),
		.data_wdata (data_wdata),
		.data_rdata (data_rdata),
		.data_ready (data_ready)
	);

	always #5 clk = ~clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic load_golden();
		int fd;
		int n;
		string line;
		byte op;
		addr_t a;
		word_t v;
		fd = $fopen("test/mem_golden.txt", "r");
		assert (fd != 0) else fail_run("Could not open the golden file test/mem_golden.txt");
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.getc(0) != "#") begin
				n = $sscanf(line, "%c %h %h", op, a, v);
				if (n == 3) begin
					ops.push_back(op);
					addrs.push_back(a);
					vals.push_back(v);
				end
			end
		end
		$fclose(fd);
		golden_loaded = 1'b1;
	endtask

	function automatic logic line_cached(input addr_t a);
		return cached[a[3:2]] && cached_tag[a[3:2]] == a[7:4];
	endfunction

	// A write to a held line drops it.
	function automatic void forget_written_line(input addr_t a);
		if (line_cached(a))
			cached[a[3:2]] = 1'b0;
	endfunction

	function automatic void record_fill(input addr_t a, input logic keep);
		cached_tag[a[3:2]] = a[7:4];
		cached[a[3:2]] = keep;
	endfunction

	task automatic data_access(input byte op, input addr_t a, input word_t v);
		int cycles;
		cycles = 0;
		@(posedge clk);
		data_addr <= a;
		data_wdata <= v;
		data_read <= (op == "R");
		data_write <= (op != "R");
		do begin
			@(posedge clk);
			cycles++;
			@(negedge clk);
		end while (!data_ready && cycles < WAIT_LIMIT);
		assert (data_ready) else
			fail_run($sformatf("No data_ready pulse for address %h within %0d cycles", a, cycles));
		assert (cycles == LATENCY + 1) else
			fail_run($sformatf("ERR %0t: data access at %h took %0d cycles, expected %0d",
				$time, a, cycles, LATENCY + 1));
		if (op == "R") begin
			assert (data_rdata === v) else
				fail_run($sformatf("ERR %0t: read at %h returned %h, expected %h",
					$time, a, data_rdata, v));
		end
		@(posedge clk);
		data_read <= 1'b0;
		data_write <= 1'b0;
	endtask

	task automatic fetch_access(input addr_t a, input word_t v, input logic exp_hit);
		int cycles;
		int exp_cycles;
		cycles = 0;
		exp_cycles = exp_hit ? 1 : LATENCY + 3; // Hit or refill.
		@(posedge clk);
		fetch_addr <= a;
		fetch_req <= 1'b1;
		do begin
			@(posedge clk);
			cycles++;
			@(negedge clk);
		end while (!fetch_ready && cycles < WAIT_LIMIT);
		assert (fetch_ready) else
			fail_run($sformatf("No fetch_ready pulse for address %h within %0d cycles", a, cycles));
		assert (cycles == exp_cycles) else
			fail_run($sformatf("ERR %0t: fetch at %h took %0d cycles, expected %0d",
				$time, a, cycles, exp_cycles));
		assert (fetch_word === v) else
			fail_run($sformatf("ERR %0t: fetch at %h returned %h, expected %h",
				$time, a, fetch_word, v));
		@(posedge clk);
		fetch_req <= 1'b0;
	endtask

	initial begin
		int i;
		logic exp_hit;
		$timeformat(-9, 0, " ns", 0);
		clk = 1'b0;
		reset_n = 1'b0;
		fetch_req = 1'b0;
		fetch_addr = '0;
		data_read = 1'b0;
		data_write = 1'b0;
		data_addr = '0;
		data_wdata = '0;
		for (i = 0; i < 4; i++) begin
			cached[i] = 1'b0;
			cached_tag[i] = '0;
		end
		load_golden();
		repeat (4) @(posedge clk);
		reset_n <= 1'b1;
		// Quiet outputs with no request pending.
		repeat (3) begin
			@(negedge clk);
			assert (!fetch_ready && !data_ready) else
				fail_run($sformatf("ERR %0t: ready pulse after reset without a request", $time));
		end
		i = 0;
		while (i < ops.size()) begin
			case (ops[i])
				"W": begin
					data_access("W", addrs[i], vals[i]);
					forget_written_line(addrs[i]);
				end
				"R": data_access("R", addrs[i], vals[i]);
				"F": begin
					exp_hit = line_cached(addrs[i]);
					fetch_access(addrs[i], vals[i], exp_hit);
					if (!exp_hit)
						record_fill(addrs[i], 1'b1);
				end
				"P": begin
					assert (i + 1 < ops.size() && ops[i+1] == "F") else
						fail_run("Golden file has a paired write without a following fetch");
					exp_hit = line_cached(addrs[i+1]);
					// Write starts one cycle after the fetch, so it lands inside the refill.
					fork
						fetch_access(addrs[i+1], vals[i+1], exp_hit);
						begin
							@(posedge clk);
							data_access("W", addrs[i], vals[i]);
						end
					join
					forget_written_line(addrs[i]);
					if (!exp_hit)
						record_fill(addrs[i+1], addrs[i][7:2] != addrs[i+1][7:2]);
					i++;
				end
				default: fail_run($sformatf("Unknown operation letter in golden line %0d", i));
			endcase
			i++;
		end
		$display("*** PASSED ***");
		$finish;
	end

	initial begin
		wait (golden_loaded);
		#((ops.size() * (LATENCY + 10) + 40) * 10);
		$display("Watchdog timeout, the operations did not finish in time");
		$display("*** FAILED ***");
		$fatal(1);
	end

endmodule

// ==== verilog/mem_subsystem.sv ====
`timescale 1ns/1ps

module mem_subsystem (
	input logic clk,
	input logic reset_n,

	input logic fetch_req,
	input mem_pkg::addr_t fetch_addr,
	output mem_pkg::word_t fetch_word,
	output logic fetch_ready,

	input logic data_read,
	input logic data_write,
	input mem_pkg::addr_t data_addr,
	input mem_pkg::word_t data_wdata,
	output mem_pkg::word_t data_rdata,
	output logic data_ready
);
	import mem_pkg::*;

	// Cache to memory instruction port.
	logic line_req;
	addr_t line_addr;
	line_t line_data;
	logic line_ready;

	icache icache_i (
		.clk (clk),
		.reset_n (reset_n),
		.fetch_req (fetch_req),
		.fetch_addr (fetch_addr),
		.fetch_word (fetch_word),
		.fetch_ready (fetch_ready),
		.line_req (line_req),
		.line_addr (line_addr),
		.line_data (line_data),
		.line_ready (line_ready),
		.data_write (data_write), // Snoop for invalidation.
		.data_addr (data_addr)
	);

	main_memory main_memory_i (
		.clk (clk),
		.reset_n (reset_n),
		.line_req (line_req),
		.line_addr (line_addr),
		.line_data (line_data),
		.line_ready (line_ready),
		.data_read (data_read),
		.data_write (data_write),
		.data_addr (data_addr),
		.data_wdata (data_wdata),
		.data_rdata (data_rdata),
		.data_ready (data_ready)
	);

endmodule

// ==== verilog/icache.sv ====
`timescale 1ns/1ps

module icache (
	input logic clk,
	input logic reset_n,

	input logic fetch_req,
	input mem_pkg::addr_t fetch_addr,
	output mem_pkg::word_t fetch_word,
	output logic fetch_ready,

	output logic line_req,
	output mem_pkg::addr_t line_addr,
	input mem_pkg::line_t line_data,
	input logic line_ready,

	// Snooped data port writes.
	input logic data_write,
	input mem_pkg::addr_t data_addr
);
	import mem_pkg::*;

	line_t lines [CACHE_LINES];
	tag_t tags [CACHE_LINES];
	logic [CACHE_LINES-1:0] valid;

	icache_state_t state;
	addr_t miss_addr;
	logic fill_stale; // Same-line write seen during refill.

	tag_t fetch_tag;
	index_t fetch_idx;
	tag_t wr_tag;
	index_t wr_idx;
	index_t miss_idx;
	logic new_fetch;
	logic hit;
	logic hit_now;
	logic miss_now;
	logic inval_hit;
	logic same_line_wr;
	logic fill_done;

	assign fetch_tag = fetch_addr[7:4];
	assign fetch_idx = fetch_addr[3:2];
	assign wr_tag = data_addr[7:4];
	assign wr_idx = data_addr[3:2];
	assign miss_idx = miss_addr[3:2];

	// Skip the cycle of our own pulse, the requester still holds fetch_req there.
	assign new_fetch = state == IDLE && fetch_req && !fetch_ready;
	assign hit = valid[fetch_idx] && tags[fetch_idx] == fetch_tag;
	assign hit_now = new_fetch && hit;
	assign miss_now = new_fetch && !hit;

	assign inval_hit = data_write && valid[wr_idx] && tags[wr_idx] == wr_tag;
	assign same_line_wr = data_write && data_addr[7:2] == miss_addr[7:2];
	assign fill_done = state == REFILL && line_ready;

	assign line_addr = miss_addr; // Memory does the alignment.

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= IDLE;
			line_req <= 1'b0;
			fetch_ready <= 1'b0;
			fill_stale <= 1'b0;
			valid <= '0;
		end else begin
			fetch_ready <= 1'b0;
			if (inval_hit)
				valid[wr_idx] <= 1'b0;
			case (state)
				IDLE: begin
					if (hit_now) begin
						fetch_ready <= 1'b1;
					end else if (miss_now) begin
						state <= REFILL;
						line_req <= 1'b1;
						fill_stale <= data_write && data_addr[7:2] == fetch_addr[7:2];
					end
				end
				REFILL: begin
					if (same_line_wr)
						fill_stale <= 1'b1;
					if (line_ready) begin
						// A fill raced by a write stays invalid.
						valid[miss_idx] <= !(fill_stale || same_line_wr);
						line_req <= 1'b0;
						fetch_ready <= 1'b1;
						state <= RESPOND;
					end
				end
				RESPOND: state <= IDLE; // Pulse cycle.
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (miss_now)
			miss_addr <= fetch_addr;
		if (hit_now)
			fetch_word <= lines[fetch_idx][fetch_addr[1:0]*$bits(word_t) +: $bits(word_t)];
		if (fill_done) begin
			lines[miss_idx] <= line_data;
			tags[miss_idx] <= miss_addr[7:4];
			fetch_word <= line_data[miss_addr[1:0]*$bits(word_t) +: $bits(word_t)];
		end
	end

	a_req_in_refill: assert property (
		@(posedge clk) disable iff (!reset_n)
		line_req |-> state == REFILL
	);

endmodule

// ==== verilog/main_memory.sv ====
`timescale 1ns/1ps

module main_memory (
	input logic clk,
	input logic reset_n,

	// Instruction port, whole line.
	input logic line_req,
	input mem_pkg::addr_t line_addr,
	output mem_pkg::line_t line_data,
	output logic line_ready,

	// Data port, single word.
	input logic data_read,
	input logic data_write,
	input mem_pkg::addr_t data_addr,
	input mem_pkg::word_t data_wdata,
	output mem_pkg::word_t data_rdata,
	output logic data_ready
);
	import mem_pkg::*;

	word_t mem [MEM_WORDS];

	cnt_t line_count;
	cnt_t data_count;
	logic line_fire;
	logic data_fire;
	logic data_req;
	logic fwd_hit;

	assign data_req = data_read || data_write;

	// Access takes place once the count has reached the latency.
	assign line_fire = line_req && line_count >= cnt_t'(MEM_LATENCY);
	assign data_fire = data_req && data_count >= cnt_t'(MEM_LATENCY);

	// Write completing together with a read of the same line.
	assign fwd_hit = data_fire && data_write && line_fire &&
		data_addr[7:2] == line_addr[7:2];

	// No counting during the ready pulse, so a back-to-back request
	// sees the full delay.
	latency_counter line_cnt_i (
		.clk (clk),
		.reset_n (reset_n),
		.restart (line_fire || !line_req),
		.enable (line_req && !line_ready),
		.count (line_count)
	);

	latency_counter data_cnt_i (
		.clk (clk),
		.reset_n (reset_n),
		.restart (data_fire || !data_req),
		.enable (data_req && !data_ready),
		.count (data_count)
	);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			line_ready <= 1'b0;
			data_ready <= 1'b0;
		end else begin
			line_ready <= line_fire; // One-cycle pulses.
			data_ready <= data_fire;
		end
	end

	// Line read, aligned down to four words.
	always_ff @(posedge clk) begin
		if (line_fire) begin
			for (int i = 0; i < LINE_WORDS; i++) begin
				line_data[i*$bits(word_t) +: $bits(word_t)] <=
					mem[{line_addr[7:2], i[1:0]}];
			end
			if (fwd_hit) begin
				line_data[data_addr[1:0]*$bits(word_t) +: $bits(word_t)] <= data_wdata;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (data_fire) begin
			if (data_write) begin
				mem[data_addr[7:0]] <= data_wdata;
			end else begin
				data_rdata <= mem[data_addr[7:0]];
			end
		end
	end

	a_one_data_op: assert property (
		@(posedge clk) disable iff (!reset_n)
		!(data_read && data_write)
	);

	a_line_pulse: assert property (
		@(posedge clk) disable iff (!reset_n)
		line_ready |=> !line_ready
	);

	a_data_pulse: assert property (
		@(posedge clk) disable iff (!reset_n)
		data_ready |=> !data_ready
	);

endmodule

// ==== verilog/latency_counter.sv ====
`timescale 1ns/1ps

module latency_counter (
	input logic clk,
	input logic reset_n,
	input logic restart,
	input logic enable,
	output mem_pkg::cnt_t count
);

	// Counts cycles of one access.
	// Restart wins over enable so a finished or aborted access starts from zero.
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			count <= '0;
		end else if (restart) begin
			count <= '0;
		end else if (enable && count != '1) begin
			count <= count + 1'b1; // Saturates at the top.
		end
	end

endmodule

// ==== verilog/mem_pkg.sv ====
package mem_pkg;

	// Memory geometry.
	localparam int MEM_WORDS = 256;
	localparam int LINE_WORDS = 4;
	localparam int CACHE_LINES = 4;

	// Counted cycles before a port access completes.
	localparam int MEM_LATENCY = 4;

	typedef logic [15:0] word_t;

	// Only bits 7:0 reach the storage.
	typedef logic [15:0] addr_t;

	// Word at offset 0 in the low bits.
	typedef logic [LINE_WORDS*16-1:0] line_t;

	typedef logic [7:0] cnt_t;

	typedef logic [1:0] index_t; // Address bits 3:2.
	typedef logic [3:0] tag_t; // Address bits 7:4.

	typedef enum logic [1:0] {
		IDLE,
		REFILL,
		RESPOND
	} icache_state_t;

endpackage
